// ==== src/tcdm_macros.svh ====
// port counts, data and address widths, and bank geometry of the TCDM interconnect.
`ifndef TCDM_MACROS_SVH
`define TCDM_MACROS_SVH

// initiator side.
`define TCDM_NB_CORES 4
`define TCDM_NB_INIT  (`TCDM_NB_CORES + 1)
`define TCDM_DMA_IDX  `TCDM_NB_CORES
`define TCDM_CORE_W   2
`define TCDM_INIT_W   3

// bus widths.
`define TCDM_DATA_W   32
`define TCDM_ADDR_W   32
`define TCDM_BE_W     (`TCDM_DATA_W / 8)

// banks are word interleaved, 64 words each.
`define TCDM_NB_BANKS 4
`define TCDM_BANK_W   2
`define TCDM_ROW_W    6
`define TCDM_STALL_W  4

`endif

// ==== src/tcdm_pkg.sv ====
// arbitration policy and priority state enums, and the bank address struct.
`default_nettype none

`include "tcdm_macros.svh"

package tcdm_pkg;

  // which side owns a bank when cores and the DMA collide.
  typedef enum logic {
    CORE_FIRST = 1'b0,
    DMA_FIRST  = 1'b1
  } arb_policy_e;

  // policy states plus one-cycle boost states against starvation.
  typedef enum logic [1:0] {
    ST_CORE       = 2'd0,
    ST_DMA        = 2'd1,
    ST_BOOST_CORE = 2'd2,
    ST_BOOST_DMA  = 2'd3
  } prio_state_e;

  // address bits 3:2 select the bank, the bits above them the row.
  typedef struct packed {
    logic [`TCDM_ROW_W-1:0]  row;
    logic [`TCDM_BANK_W-1:0] bank;
  } bank_addr_t;

endpackage

`default_nettype wire

// ==== src/tcdm_req_if.sv ====
// TCDM request/grant bundle with response valid, and its initiator and target modports.
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_macros.svh"

interface tcdm_req_if ();

  // request side.
  logic                    req;
  logic                    gnt;
  logic [`TCDM_ADDR_W-1:0] add;
  logic                    wen;
  logic [`TCDM_BE_W-1:0]   be;
  logic [`TCDM_DATA_W-1:0] wdata;

  // response side, one cycle after the grant.
  logic                    r_valid;
  logic [`TCDM_DATA_W-1:0] r_rdata;

  modport initiator (
    output req, add, wen, be, wdata,
    input  gnt, r_valid, r_rdata
  );

  modport target (
    input  req, add, wen, be, wdata,
    output gnt, r_valid, r_rdata
  );

endinterface

`default_nettype wire

// ==== src/prio_fsm.sv ====
// priority FSM choosing core or DMA precedence, with one-cycle starvation boost.
`timescale 1ns/1ps
`default_nettype none

module prio_fsm import tcdm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  arb_policy_e policy_i,
  input  logic        stall_hit_i,
  output logic        dma_wins_o
);

  prio_state_e state_q;
  prio_state_e state_d;
  prio_state_e policy_state;

  assign policy_state = (policy_i == DMA_FIRST) ? ST_DMA : ST_CORE;

  // a stall hit hands the next cycle to the side that kept losing.
  always_comb begin
    state_d = policy_state;
    case (state_q)
      ST_CORE: begin
        if (stall_hit_i) begin
          state_d = ST_BOOST_DMA;
        end
      end
      ST_DMA: begin
        if (stall_hit_i) begin
          state_d = ST_BOOST_CORE;
        end
      end
      default: state_d = policy_state;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= policy_state;
    end else begin
      state_q <= state_d;
    end
  end

  assign dma_wins_o = (state_q == ST_DMA) || (state_q == ST_BOOST_DMA);

  // boost is a single cycle, never two in a row.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q inside {ST_BOOST_CORE, ST_BOOST_DMA}) |=>
      !(state_q inside {ST_BOOST_CORE, ST_BOOST_DMA}));

endmodule

`default_nettype wire

// ==== src/stall_counter.sv ====
// counter of consecutive cycles in which the low-priority side lost arbitration.
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_macros.svh"

module stall_counter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     refused_i,
  input  logic [`TCDM_STALL_W-1:0] max_stall_i,
  output logic                     stall_hit_o
);

  logic [`TCDM_STALL_W-1:0] count_q;
  logic [`TCDM_STALL_W-1:0] count_inc;

  assign count_inc = count_q + 1'b1;

  // zero limit means boosting is off.
  assign stall_hit_o = refused_i && (max_stall_i != '0) && (count_inc == max_stall_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (!refused_i || stall_hit_o) begin
      count_q <= '0;
    end else begin
      count_q <= count_inc;
    end
  end

endmodule

`default_nettype wire

// ==== src/bank_arbiter.sv ====
// per-bank arbiter with core round-robin and core/DMA side priority.
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_macros.svh"

module bank_arbiter import tcdm_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`TCDM_BANK_W-1:0]  bank_idx_i,
  tcdm_req_if.target               init [`TCDM_NB_INIT],
  input  logic                     dma_wins_i,
  output logic                     bank_req_o,
  output logic [`TCDM_ROW_W-1:0]   bank_row_o,
  output logic                     bank_wen_o,
  output logic [`TCDM_BE_W-1:0]    bank_be_o,
  output logic [`TCDM_DATA_W-1:0]  bank_wdata_o,
  output logic [`TCDM_INIT_W-1:0]  winner_o,
  output logic                     refused_o
);

  bank_addr_t               dec   [`TCDM_NB_INIT];
  logic [`TCDM_BE_W-1:0]    be    [`TCDM_NB_INIT];
  logic [`TCDM_DATA_W-1:0]  wdata [`TCDM_NB_INIT];
  logic [`TCDM_NB_INIT-1:0] match;
  logic [`TCDM_NB_INIT-1:0] wen;
  logic [`TCDM_NB_INIT-1:0] gnt_in;
  logic [`TCDM_NB_INIT-1:0] gnt_vec;
  logic [`TCDM_CORE_W-1:0]  rr_ptr_q;
  logic [`TCDM_CORE_W-1:0]  core_win;
  logic                     core_any;
  logic                     dma_req;
  logic                     dma_sel;

  for (genvar k = 0; k < `TCDM_NB_INIT; k++) begin : gen_unpack
    assign dec[k]    = bank_addr_t'(init[k].add[`TCDM_ROW_W+`TCDM_BANK_W+1:2]);
    assign match[k]  = init[k].req && (dec[k].bank == bank_idx_i);
    assign wen[k]    = init[k].wen;
    assign be[k]     = init[k].be;
    assign wdata[k]  = init[k].wdata;
    assign gnt_in[k] = init[k].gnt;
  end

  // scan downwards so the core nearest the pointer is picked last and wins.
  always_comb begin
    logic [`TCDM_CORE_W-1:0] idx;
    core_any = 1'b0;
    core_win = rr_ptr_q;
    for (int i = `TCDM_NB_CORES - 1; i >= 0; i--) begin
      idx = rr_ptr_q + `TCDM_CORE_W'(i);
      if (match[idx]) begin
        core_any = 1'b1;
        core_win = idx;
      end
    end
  end

  assign dma_req = match[`TCDM_DMA_IDX];
  assign dma_sel = dma_req && (dma_wins_i || !core_any);

  always_comb begin
    gnt_vec = '0;
    if (dma_sel) begin
      gnt_vec[`TCDM_DMA_IDX] = 1'b1;
    end else if (core_any) begin
      gnt_vec[core_win] = 1'b1;
    end
  end

  assign winner_o     = dma_sel ? `TCDM_INIT_W'(`TCDM_DMA_IDX) : `TCDM_INIT_W'(core_win);
  assign bank_req_o   = |gnt_vec;
  assign bank_row_o   = dec[winner_o].row;
  assign bank_wen_o   = wen[winner_o];
  assign bank_be_o    = be[winner_o];
  assign bank_wdata_o = wdata[winner_o];

  // a collision always leaves the lower side waiting.
  assign refused_o = core_any && dma_req;

  // pointer moves past the core just served.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (core_any && !dma_sel) begin
      rr_ptr_q <= core_win + 1'b1;
    end
  end

  // grants seen by initiators on this bank are at most one, and the arbiter's pick.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_in & match) && ((gnt_in & match) == gnt_vec));

endmodule

`default_nettype wire

// ==== src/tcdm_bank.sv ====
// single-port SRAM bank with byte enables and registered one-cycle response.
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_macros.svh"

module tcdm_bank (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_i,
  input  logic [`TCDM_ROW_W-1:0]  row_i,
  input  logic                    wen_i,
  input  logic [`TCDM_BE_W-1:0]   be_i,
  input  logic [`TCDM_DATA_W-1:0] wdata_i,
  output logic [`TCDM_DATA_W-1:0] rdata_o,
  output logic                    valid_o
);

  logic [`TCDM_DATA_W-1:0] mem_q [2**`TCDM_ROW_W];

  // writes answer with zero data.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (wen_i) begin
        rdata_o <= mem_q[row_i];
      end else begin
        for (int i = 0; i < `TCDM_BE_W; i++) begin
          if (be_i[i]) begin
            mem_q[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
        rdata_o <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= req_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/resp_router.sv ====
// response router steering each bank's valid and read data back to its winner.
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_macros.svh"

module resp_router (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic [`TCDM_NB_BANKS-1:0][`TCDM_INIT_W-1:0]  winner_i,
  input  logic [`TCDM_NB_BANKS-1:0]                    bank_valid_i,
  input  logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_W-1:0]  bank_rdata_i,
  tcdm_req_if.target                                   init [`TCDM_NB_INIT]
);

  // winner index lines up with the bank's valid one cycle later.
  logic [`TCDM_NB_BANKS-1:0][`TCDM_INIT_W-1:0] winner_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      winner_q <= '0;
    end else begin
      winner_q <= winner_i;
    end
  end

  for (genvar k = 0; k < `TCDM_NB_INIT; k++) begin : gen_route
    logic [`TCDM_NB_BANKS-1:0] hit;
    logic [`TCDM_DATA_W-1:0]   rdata;

    always_comb begin
      rdata = '0;
      for (int b = 0; b < `TCDM_NB_BANKS; b++) begin
        hit[b] = bank_valid_i[b] && (winner_q[b] == `TCDM_INIT_W'(k));
        if (hit[b]) begin
          rdata = bank_rdata_i[b];
        end
      end
    end

    assign init[k].r_valid = |hit;
    assign init[k].r_rdata = rdata;

    // one grant per initiator per cycle means one response back.
    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(hit));
  end

endmodule

`default_nettype wire

// ==== src/tcdm_interconnect_top.sv ====
// top level of the TCDM interconnect with banks, arbiters, router and priority control.
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_macros.svh"

module tcdm_interconnect_top import tcdm_pkg::*; (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  arb_policy_e                                policy_i,
  input  logic [`TCDM_STALL_W-1:0]                   max_stall_i,
  input  logic [`TCDM_NB_INIT-1:0]                   init_req_i,
  input  logic [`TCDM_NB_INIT-1:0][`TCDM_ADDR_W-1:0] init_add_i,
  input  logic [`TCDM_NB_INIT-1:0]                   init_wen_i,
  input  logic [`TCDM_NB_INIT-1:0][`TCDM_BE_W-1:0]   init_be_i,
  input  logic [`TCDM_NB_INIT-1:0][`TCDM_DATA_W-1:0] init_wdata_i,
  output logic [`TCDM_NB_INIT-1:0]                   init_gnt_o,
  output logic [`TCDM_NB_INIT-1:0]                   init_r_valid_o,
  output logic [`TCDM_NB_INIT-1:0][`TCDM_DATA_W-1:0] init_r_rdata_o
);

  logic [`TCDM_NB_BANKS-1:0]                   bank_req;
  logic [`TCDM_NB_BANKS-1:0][`TCDM_ROW_W-1:0]  bank_row;
  logic [`TCDM_NB_BANKS-1:0]                   bank_wen;
  logic [`TCDM_NB_BANKS-1:0][`TCDM_BE_W-1:0]   bank_be;
  logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_W-1:0] bank_wdata;
  logic [`TCDM_NB_BANKS-1:0][`TCDM_DATA_W-1:0] bank_rdata;
  logic [`TCDM_NB_BANKS-1:0]                   bank_valid;
  logic [`TCDM_NB_BANKS-1:0][`TCDM_INIT_W-1:0] winner;
  logic [`TCDM_NB_BANKS-1:0]                   refused;
  logic                                        stall_hit;
  logic                                        dma_wins;

  tcdm_req_if init_if [`TCDM_NB_INIT] ();

  // an initiator is granted when the bank it addresses picked it.
  for (genvar k = 0; k < `TCDM_NB_INIT; k++) begin : gen_init
    bank_addr_t dec;

    assign dec                = bank_addr_t'(init_add_i[k][`TCDM_ROW_W+`TCDM_BANK_W+1:2]);
    assign init_if[k].req     = init_req_i[k];
    assign init_if[k].add     = init_add_i[k];
    assign init_if[k].wen     = init_wen_i[k];
    assign init_if[k].be      = init_be_i[k];
    assign init_if[k].wdata   = init_wdata_i[k];
    assign init_if[k].gnt     = bank_req[dec.bank] && (winner[dec.bank] == `TCDM_INIT_W'(k));
    assign init_gnt_o[k]      = init_if[k].gnt;
    assign init_r_valid_o[k]  = init_if[k].r_valid;
    assign init_r_rdata_o[k]  = init_if[k].r_rdata;
  end

  for (genvar b = 0; b < `TCDM_NB_BANKS; b++) begin : gen_bank
    bank_arbiter bank_arbiter_i (
      .clk_i        ( clk_i               ),
      .rst_n_i      ( rst_n_i             ),
      .bank_idx_i   ( `TCDM_BANK_W'(b)    ),
      .init         ( init_if             ),
      .dma_wins_i   ( dma_wins            ),
      .bank_req_o   ( bank_req[b]         ),
      .bank_row_o   ( bank_row[b]         ),
      .bank_wen_o   ( bank_wen[b]         ),
      .bank_be_o    ( bank_be[b]          ),
      .bank_wdata_o ( bank_wdata[b]       ),
      .winner_o     ( winner[b]           ),
      .refused_o    ( refused[b]          )
    );

    tcdm_bank tcdm_bank_i (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .req_i   ( bank_req[b]   ),
      .row_i   ( bank_row[b]   ),
      .wen_i   ( bank_wen[b]   ),
      .be_i    ( bank_be[b]    ),
      .wdata_i ( bank_wdata[b] ),
      .rdata_o ( bank_rdata[b] ),
      .valid_o ( bank_valid[b] )
    );
  end

  resp_router resp_router_i (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .winner_i     ( winner     ),
    .bank_valid_i ( bank_valid ),
    .bank_rdata_i ( bank_rdata ),
    .init         ( init_if    )
  );

  // starvation is tracked globally over all banks.
  stall_counter stall_counter_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .refused_i   ( |refused    ),
    .max_stall_i ( max_stall_i ),
    .stall_hit_o ( stall_hit   )
  );

  prio_fsm prio_fsm_i (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .policy_i    ( policy_i  ),
    .stall_hit_i ( stall_hit ),
    .dma_wins_o  ( dma_wins  )
  );

endmodule

`default_nettype wire

// ==== verif/tb_tcdm_interconnect.sv ====
// testbench for the TCDM interconnect top level, driven by the golden record file.
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_macros.svh"

module tb_tcdm_interconnect import tcdm_pkg::*; ();

  localparam int MAX_REC = 64;
  localparam int NB_FLD  = 23;

  logic                                       clk;
  logic                                       rst_n;
  arb_policy_e                                policy;
  logic [`TCDM_STALL_W-1:0]                   max_stall;
  logic [`TCDM_NB_INIT-1:0]                   req;
  logic [`TCDM_NB_INIT-1:0][`TCDM_ADDR_W-1:0] add;
  logic [`TCDM_NB_INIT-1:0]                   wen;
  logic [`TCDM_NB_INIT-1:0][`TCDM_BE_W-1:0]   be;
  logic [`TCDM_NB_INIT-1:0][`TCDM_DATA_W-1:0] wdata;
  logic [`TCDM_NB_INIT-1:0]                   gnt;
  logic [`TCDM_NB_INIT-1:0]                   r_valid;
  logic [`TCDM_NB_INIT-1:0][`TCDM_DATA_W-1:0] r_rdata;

  // one golden record per clock cycle.
  arb_policy_e                                rec_policy [MAX_REC];
  logic [`TCDM_STALL_W-1:0]                   rec_stall  [MAX_REC];
  logic [`TCDM_NB_INIT-1:0]                   rec_req    [MAX_REC];
  logic [`TCDM_NB_INIT-1:0]                   rec_wen    [MAX_REC];
  logic [`TCDM_NB_INIT-1:0][`TCDM_BE_W-1:0]   rec_be     [MAX_REC];
  logic [`TCDM_NB_INIT-1:0][`TCDM_ADDR_W-1:0] rec_add    [MAX_REC];
  logic [`TCDM_NB_INIT-1:0][`TCDM_DATA_W-1:0] rec_wdata  [MAX_REC];
  logic [`TCDM_NB_INIT-1:0]                   rec_gnt    [MAX_REC];
  logic [`TCDM_NB_INIT-1:0]                   rec_vld    [MAX_REC];
  prio_state_e                                rec_state  [MAX_REC];
  logic [`TCDM_NB_INIT-1:0][`TCDM_DATA_W-1:0] rec_rdata  [MAX_REC];

  int n_rec        = 0;
  int cycles       = 0;
  int cycle_limit  = 1000;
  int hs_errs      = 0;
  int rdata_errs   = 0;
  int state_errs   = 0;
  int other_errs   = 0;

  tcdm_interconnect_top tcdm_interconnect_top_i (
    .clk_i          ( clk       ),
    .rst_n_i        ( rst_n     ),
    .policy_i       ( policy    ),
    .max_stall_i    ( max_stall ),
    .init_req_i     ( req       ),
    .init_add_i     ( add       ),
    .init_wen_i     ( wen       ),
    .init_be_i      ( be        ),
    .init_wdata_i   ( wdata     ),
    .init_gnt_o     ( gnt       ),
    .init_r_valid_o ( r_valid   ),
    .init_r_rdata_o ( r_rdata   )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // watchdog against a run that never ends.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic load_golden();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [NB_FLD];
    fd = $fopen("verif/interconnect_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file");
      other_errs++;
      return;
    end
    while (!$feof(fd) && n_rec < MAX_REC) begin
      cnt = $fgets(line, fd);
      if (cnt == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                    f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
      if (cnt != NB_FLD) begin
        $display("golden record %0d is malformed", n_rec);
        other_errs++;
        continue;
      end
      rec_policy[n_rec] = arb_policy_e'(f[0][0]);
      rec_stall[n_rec]  = f[1][`TCDM_STALL_W-1:0];
      rec_req[n_rec]    = f[2][`TCDM_NB_INIT-1:0];
      rec_wen[n_rec]    = f[3][`TCDM_NB_INIT-1:0];
      rec_be[n_rec]     = f[4][`TCDM_NB_INIT*`TCDM_BE_W-1:0];
      rec_gnt[n_rec]    = f[15][`TCDM_NB_INIT-1:0];
      rec_vld[n_rec]    = f[16][`TCDM_NB_INIT-1:0];
      rec_state[n_rec]  = prio_state_e'(f[17][1:0]);
      for (int k = 0; k < `TCDM_NB_INIT; k++) begin
        rec_add[n_rec][k]   = f[5+k];
        rec_wdata[n_rec][k] = f[10+k];
        rec_rdata[n_rec][k] = f[18+k];
      end
      n_rec++;
    end
    $fclose(fd);
  endtask

  task automatic check_gnt(input string name, input logic [`TCDM_NB_INIT-1:0] got,
                           input logic [`TCDM_NB_INIT-1:0] exp, input int idx);
    if (got !== exp) begin
      $display("Fail %s record %0d: got %h expected %h", name, idx, got, exp);
      hs_errs++;
    end
  endtask

  task automatic check_rdata(input int k, input logic [`TCDM_DATA_W-1:0] got,
                             input logic [`TCDM_DATA_W-1:0] exp, input int idx);
    if (got !== exp) begin
      $display("Fail init_r_rdata_o[%0d] record %0d: got %h expected %h", k, idx, got, exp);
      rdata_errs++;
    end
  endtask

  task automatic check_policy_state(input prio_state_e got, input prio_state_e exp,
                                    input int idx);
    if (got !== exp) begin
      $display("Fail prio_fsm state_q record %0d: got %h expected %h", idx, got, exp);
      state_errs++;
    end
  endtask

  task automatic drive_record(input int n);
    policy    <= rec_policy[n];
    max_stall <= rec_stall[n];
    req       <= rec_req[n];
    add       <= rec_add[n];
    wen       <= rec_wen[n];
    be        <= rec_be[n];
    wdata     <= rec_wdata[n];
  endtask

  task automatic check_record(input int n);
    check_gnt("init_gnt_o", gnt, rec_gnt[n], n);
    check_gnt("init_r_valid_o", r_valid, rec_vld[n], n);
    check_policy_state(tcdm_interconnect_top_i.prio_fsm_i.state_q, rec_state[n], n);
    for (int k = 0; k < `TCDM_NB_INIT; k++) begin
      check_rdata(k, r_rdata[k], rec_rdata[n][k], n);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    policy    = CORE_FIRST;
    max_stall = '0;
    req       = '0;
    add       = '0;
    wen       = '0;
    be        = '0;
    wdata     = '0;
    load_golden();
    if (n_rec == 0) begin
      $display("no golden records were loaded");
      other_errs++;
    end
    cycle_limit = 10 * n_rec;
    // outputs stay quiet while reset is held, three edges in all.
    for (int i = 0; i < 2; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_gnt("init_gnt_o", gnt, '0, -1);
      check_gnt("init_r_valid_o", r_valid, '0, -1);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    for (int n = 0; n < n_rec; n++) begin
      drive_record(n);
      @(negedge clk);
      check_record(n);
      @(posedge clk);
    end
    $display("errors: handshake %0d, rdata %0d, state %0d, other %0d",
             hs_errs, rdata_errs, state_errs, other_errs);
    if (hs_errs + rdata_errs + state_errs + other_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/tcdm_pkg.sv
src/tcdm_req_if.sv
src/prio_fsm.sv
src/stall_counter.sv
src/bank_arbiter.sv
src/tcdm_bank.sv
src/resp_router.sv
src/tcdm_interconnect_top.sv
verif/tb_tcdm_interconnect.sv

// ==== Makefile ====
# Verilator build and run of the TCDM interconnect testbench.

TOP     ?= tb_tcdm_interconnect
FLIST   ?= flist.f
VFLAGS  ?= --binary --timing -j 0
OBJ_DIR ?= obj_dir
PASS    ?= Test completed successfully

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the output.
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/interconnect_golden.txt ====
# pol stall req wen be a0 a1 a2 a3 a4 wd0 wd1 wd2 wd3 wd4 gnt vld state rd0 rd1 rd2 rd3 rd4
# all hex, vector bit k is initiator k, be has one digit per initiator with initiator 4 first
0 0 0f 00 0ffff 00 00 00 00 00 a000 a001 a002 a003 0000 01 00 0 0000 0000 0000 0000 0000
0 0 0f 00 0ffff 00 00 00 00 00 a000 a001 a002 a003 0000 02 01 0 0000 0000 0000 0000 0000
0 0 0f 00 0ffff 00 00 00 00 00 a000 a001 a002 a003 0000 04 02 0 0000 0000 0000 0000 0000
0 0 0f 00 0ffff 00 00 00 00 00 a000 a001 a002 a003 0000 08 04 0 0000 0000 0000 0000 0000
0 0 0f 00 0ffff 00 14 28 3c 00 1010 2121 3232 4343 0000 0f 08 0 0000 0000 0000 0000 0000
0 0 0f 00 0ffff 04 18 2c 30 00 1111 2222 3333 4040 0000 0f 0f 0 0000 0000 0000 0000 0000
0 0 0f 00 0ffff 08 1c 20 34 00 1212 2323 3030 4141 0000 0f 0f 0 0000 0000 0000 0000 0000
0 0 0f 00 0ffff 0c 10 24 38 00 1313 2020 3131 4242 0000 0f 0f 0 0000 0000 0000 0000 0000
0 0 10 00 f0000 00 00 00 00 40 0000 0000 0000 0000 5050 10 0f 0 0000 0000 0000 0000 0000
0 0 10 00 f0000 00 00 00 00 44 0000 0000 0000 0000 5151 10 10 0 0000 0000 0000 0000 0000
0 0 10 00 f0000 00 00 00 00 48 0000 0000 0000 0000 5252 10 10 0 0000 0000 0000 0000 0000
0 0 11 00 f0001 00 00 00 00 4c 00ee 0000 0000 0000 5353 11 10 0 0000 0000 0000 0000 0000
0 0 0f 0f 00000 00 14 28 3c 00 0000 0000 0000 0000 0000 0f 11 0 0000 0000 0000 0000 0000
0 0 0f 0f 00000 04 18 2c 30 00 0000 0000 0000 0000 0000 0f 0f 0 10ee 2121 3232 4343 0000
0 0 0f 0f 00000 08 1c 20 34 00 0000 0000 0000 0000 0000 0f 0f 0 1111 2222 3333 4040 0000
0 0 0f 0f 00000 0c 10 24 38 00 0000 0000 0000 0000 0000 0f 0f 0 1212 2323 3030 4141 0000
0 0 10 10 00000 00 00 00 00 40 0000 0000 0000 0000 0000 10 0f 0 1313 2020 3131 4242 0000
0 0 10 10 00000 00 00 00 00 44 0000 0000 0000 0000 0000 10 10 0 0000 0000 0000 0000 5050
0 0 10 10 00000 00 00 00 00 48 0000 0000 0000 0000 0000 10 10 0 0000 0000 0000 0000 5151
0 0 10 10 00000 00 00 00 00 4c 0000 0000 0000 0000 0000 10 10 0 0000 0000 0000 0000 5252
0 0 11 11 00000 04 00 00 00 44 0000 0000 0000 0000 0000 01 10 0 0000 0000 0000 0000 5353
1 0 00 00 00000 00 00 00 00 00 0000 0000 0000 0000 0000 00 01 0 1111 0000 0000 0000 0000
1 0 11 11 00000 04 00 00 00 44 0000 0000 0000 0000 0000 10 00 1 0000 0000 0000 0000 0000
0 0 00 00 00000 00 00 00 00 00 0000 0000 0000 0000 0000 00 10 1 0000 0000 0000 0000 5151
0 2 11 11 00000 08 00 00 00 48 0000 0000 0000 0000 0000 01 00 0 0000 0000 0000 0000 0000
0 2 11 11 00000 08 00 00 00 48 0000 0000 0000 0000 0000 01 01 0 1212 0000 0000 0000 0000
0 2 11 11 00000 08 00 00 00 48 0000 0000 0000 0000 0000 10 01 3 1212 0000 0000 0000 0000
0 2 01 01 00000 08 00 00 00 48 0000 0000 0000 0000 0000 01 10 0 0000 0000 0000 0000 5252
0 0 11 11 00000 08 00 00 00 48 0000 0000 0000 0000 0000 01 01 0 1212 0000 0000 0000 0000
0 0 11 11 00000 08 00 00 00 48 0000 0000 0000 0000 0000 01 01 0 1212 0000 0000 0000 0000
0 0 11 11 00000 08 00 00 00 48 0000 0000 0000 0000 0000 01 01 0 1212 0000 0000 0000 0000
0 0 00 00 00000 00 00 00 00 00 0000 0000 0000 0000 0000 00 01 0 1212 0000 0000 0000 0000
0 0 06 06 00000 00 1c 2c 00 00 0000 0000 0000 0000 0000 02 00 0 0000 0000 0000 0000 0000
0 0 04 04 00000 00 1c 2c 00 00 0000 0000 0000 0000 0000 04 02 0 0000 2323 0000 0000 0000
0 0 00 00 00000 00 00 00 00 00 0000 0000 0000 0000 0000 00 04 0 0000 0000 3333 0000 0000
0 0 00 00 00000 00 00 00 00 00 0000 0000 0000 0000 0000 00 00 0 0000 0000 0000 0000 0000
